//--- src/exec_pkg.sv
// ------------------------------
// Execute stage datapath widths,
// ALU operation and operand size
// encodings
// ------------------------------
`default_nettype none

package exec_pkg;

    localparam int data_w = 32;
    localparam int reg_w = 3;

    typedef enum logic [3:0] {
        op_add    = 4'd0,   // a + b
        op_adc    = 4'd1,   // a + b + CF
        op_sub    = 4'd2,   // a - b
        op_cmp    = 4'd3,   // a - b, flags only
        op_and    = 4'd4,
        op_or     = 4'd5,
        op_xor    = 4'd6,
        op_shl    = 4'd7,   // logical left by b[4:0]
        op_shr    = 4'd8,   // logical right by b[4:0]
        op_pass_b = 4'd9,   // move b, no flags
        op_jcc    = 4'd10,  // conditional jump
        op_std    = 4'd11,  // set DF
        op_cld    = 4'd12   // clear DF
    } alu_op_e;

    typedef enum logic [1:0] {
        size_8  = 2'd0,
        size_16 = 2'd1,
        size_32 = 2'd2
    } opsize_e;

    // Result, dest reg, op, jump taken, jump target, mispredict
    localparam int pipe_w = data_w + reg_w + $bits(alu_op_e) + 1 + data_w + 1;

endpackage

`default_nettype wire

//--- src/flags_pkg.sv
// ------------------------------
// Flag bit positions and branch
// condition encoding
// ------------------------------
`default_nettype none

package flags_pkg;

    localparam int flag_n = 6;

    // Bit positions in the flags vector
    localparam int flag_cf = 0;
    localparam int flag_zf = 1;
    localparam int flag_sf = 2;
    localparam int flag_of = 3;
    localparam int flag_pf = 4;
    localparam int flag_df = 5;

    typedef enum logic [2:0] {
        cond_z      = 3'd0,
        cond_nz     = 3'd1,
        cond_c      = 3'd2,
        cond_nc     = 3'd3,
        cond_s      = 3'd4,
        cond_ns     = 3'd5,
        cond_o      = 3'd6,
        cond_always = 3'd7
    } cond_e;

endpackage

`default_nettype wire

//--- src/alu.sv
// ------------------------------
// Combinational ALU with flag
// generation and branch resolve
// ------------------------------
`default_nettype none

module alu (
    input  exec_pkg::alu_op_e                op,
    input  exec_pkg::opsize_e                opsize,
    input  flags_pkg::cond_e                 cond,
    input  logic [exec_pkg::data_w-1:0]      op_a,
    input  logic [exec_pkg::data_w-1:0]      op_b,
    input  logic [exec_pkg::data_w-1:0]      pc,
    input  logic [flags_pkg::flag_n-1:0]     flags_in,
    output logic [exec_pkg::data_w-1:0]      result,
    output logic [flags_pkg::flag_n-1:0]     flags_out,
    output logic [flags_pkg::flag_n-1:0]     flags_mask,
    output logic                             jump_taken,
    output logic [exec_pkg::data_w-1:0]      jump_address
);

    // Flags written by any result-producing operation
    localparam logic [flags_pkg::flag_n-1:0] res_mask =
        (1 << flags_pkg::flag_cf) | (1 << flags_pkg::flag_zf) |
        (1 << flags_pkg::flag_sf) | (1 << flags_pkg::flag_of) |
        (1 << flags_pkg::flag_pf);

    logic [exec_pkg::data_w-1:0] size_mask;
    logic [exec_pkg::data_w-1:0] a_m;
    logic [exec_pkg::data_w-1:0] b_m;
    logic [exec_pkg::data_w:0]   sum;
    logic [exec_pkg::data_w:0]   diff;
    logic [exec_pkg::data_w-1:0] raw;
    logic                        cin;
    logic                        carry_out;
    logic                        borrow_out;
    logic                        sign_a;
    logic                        sign_b;
    logic                        sign_r;
    logic                        cond_true;

    always_comb begin
        case (opsize)
            exec_pkg::size_8:  size_mask = 32'h0000_00ff;
            exec_pkg::size_16: size_mask = 32'h0000_ffff;
            default:           size_mask = 32'hffff_ffff;
        endcase
    end

    assign a_m  = op_a & size_mask;
    assign b_m  = op_b & size_mask;
    assign cin  = (op == exec_pkg::op_adc) & flags_in[flags_pkg::flag_cf];
    assign sum  = {1'b0, a_m} + {1'b0, b_m} + {{exec_pkg::data_w{1'b0}}, cin};
    assign diff = {1'b0, a_m} - {1'b0, b_m};

    always_comb begin
        case (op)
            exec_pkg::op_add,
            exec_pkg::op_adc:    raw = sum[exec_pkg::data_w-1:0];
            exec_pkg::op_sub,
            exec_pkg::op_cmp:    raw = diff[exec_pkg::data_w-1:0];
            exec_pkg::op_and:    raw = a_m & b_m;
            exec_pkg::op_or:     raw = a_m | b_m;
            exec_pkg::op_xor:    raw = a_m ^ b_m;
            exec_pkg::op_shl:    raw = a_m << op_b[4:0];
            exec_pkg::op_shr:    raw = a_m >> op_b[4:0];
            exec_pkg::op_pass_b: raw = b_m;
            default:             raw = '0;
        endcase
    end

    assign result = raw & size_mask;

    // Carry and sign taken at the top bit of the operand size
    always_comb begin
        case (opsize)
            exec_pkg::size_8: begin
                carry_out  = sum[8];
                borrow_out = diff[8];
                sign_a     = a_m[7];
                sign_b     = b_m[7];
                sign_r     = result[7];
            end
            exec_pkg::size_16: begin
                carry_out  = sum[16];
                borrow_out = diff[16];
                sign_a     = a_m[15];
                sign_b     = b_m[15];
                sign_r     = result[15];
            end
            default: begin
                carry_out  = sum[32];
                borrow_out = diff[32];
                sign_a     = a_m[31];
                sign_b     = b_m[31];
                sign_r     = result[31];
            end
        endcase
    end

    always_comb begin
        flags_out  = flags_in;
        flags_mask = '0;
        case (op)
            exec_pkg::op_add, exec_pkg::op_adc: begin
                flags_mask                  = res_mask;
                flags_out[flags_pkg::flag_cf] = carry_out;
                flags_out[flags_pkg::flag_of] = (sign_a == sign_b) && (sign_r != sign_a);
            end
            exec_pkg::op_sub, exec_pkg::op_cmp: begin
                flags_mask                  = res_mask;
                flags_out[flags_pkg::flag_cf] = borrow_out;
                flags_out[flags_pkg::flag_of] = (sign_a != sign_b) && (sign_r != sign_a);
            end
            exec_pkg::op_and, exec_pkg::op_or, exec_pkg::op_xor,
            exec_pkg::op_shl, exec_pkg::op_shr: begin
                flags_mask                  = res_mask;
                flags_out[flags_pkg::flag_cf] = 1'b0;
                flags_out[flags_pkg::flag_of] = 1'b0;
            end
            exec_pkg::op_std, exec_pkg::op_cld: begin
                flags_mask[flags_pkg::flag_df] = 1'b1;
                flags_out[flags_pkg::flag_df]  = (op == exec_pkg::op_std);
            end
            default: ;
        endcase
        if (flags_mask[flags_pkg::flag_zf]) begin
            flags_out[flags_pkg::flag_zf] = (result == '0);
            flags_out[flags_pkg::flag_sf] = sign_r;
            // Even parity of the low byte
            flags_out[flags_pkg::flag_pf] = ~^result[7:0];
        end
    end

    always_comb begin
        case (cond)
            flags_pkg::cond_z:  cond_true = flags_in[flags_pkg::flag_zf];
            flags_pkg::cond_nz: cond_true = !flags_in[flags_pkg::flag_zf];
            flags_pkg::cond_c:  cond_true = flags_in[flags_pkg::flag_cf];
            flags_pkg::cond_nc: cond_true = !flags_in[flags_pkg::flag_cf];
            flags_pkg::cond_s:  cond_true = flags_in[flags_pkg::flag_sf];
            flags_pkg::cond_ns: cond_true = !flags_in[flags_pkg::flag_sf];
            flags_pkg::cond_o:  cond_true = flags_in[flags_pkg::flag_of];
            default:            cond_true = 1'b1;
        endcase
    end

    assign jump_taken   = (op == exec_pkg::op_jcc) && cond_true;
    assign jump_address = pc + op_b;

    // Decode must never hand over an unassigned op code
    always_comb begin
        if (!$isunknown(op)) begin
            assert (op <= exec_pkg::op_cld)
                else $error("alu: undefined op %0d", op);
        end
    end

endmodule

`default_nettype wire

//--- src/eflags.sv
// ------------------------------
// Architectural flags register
// ------------------------------
`default_nettype none

module eflags (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          write,
    input  logic [flags_pkg::flag_n-1:0]  flags_in,
    input  logic [flags_pkg::flag_n-1:0]  flags_mask,
    output logic [flags_pkg::flag_n-1:0]  flags_out
);

    logic [flags_pkg::flag_n-1:0] flags_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            flags_q <= '0;
        end else if (write) begin
            // Only the masked bits take the new value
            flags_q <= (flags_q & ~flags_mask) | (flags_in & flags_mask);
        end
    end

    assign flags_out = flags_q;

    a_masked_write: assert property (
        @(posedge clk) disable iff (rst)
        write |=> ((flags_out & $past(flags_mask)) == ($past(flags_in) & $past(flags_mask)))
    ) else $error("eflags: masked write not visible next cycle");

endmodule

`default_nettype wire

//--- src/pipestage.sv
// ------------------------------
// One-entry valid/ready register
// slice with flush
// ------------------------------
`default_nettype none

module pipestage #(
    parameter int width = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [width-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [width-1:0] out_data
);

    logic             valid_q;
    logic [width-1:0] data_q;

    // Room when empty or when the held item leaves this cycle
    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out_data)
    ) else $error("pipestage: output changed while stalled");

endmodule

`default_nettype wire

//--- src/execute_top.sv
// ------------------------------
// Execute stage top level
// ALU, flags register and the
// writeback pipe register
// ------------------------------
`default_nettype none

module execute_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            flush,

    // From decode
    input  logic                            e_valid,
    output logic                            e_ready,
    input  exec_pkg::alu_op_e               e_op,
    input  exec_pkg::opsize_e               e_opsize,
    input  flags_pkg::cond_e                e_cond,
    input  logic [exec_pkg::data_w-1:0]     e_op_a,
    input  logic [exec_pkg::data_w-1:0]     e_op_b,
    input  logic [exec_pkg::data_w-1:0]     e_pc,
    input  logic [exec_pkg::reg_w-1:0]      e_dest_reg,
    input  logic                            e_branch_taken,

    // To writeback
    input  logic                            wb_ready,
    output logic                            wb_valid,
    output logic [exec_pkg::data_w-1:0]     wb_result,
    output logic [exec_pkg::reg_w-1:0]      wb_dest_reg,
    output exec_pkg::alu_op_e               wb_alu_op,
    output logic                            wb_jump_load_address,
    output logic [exec_pkg::data_w-1:0]     wb_jump_address,
    output logic                            wb_br_misprediction
);

    logic [exec_pkg::data_w-1:0]     alu_result;
    logic [flags_pkg::flag_n-1:0]    alu_flags;
    logic [flags_pkg::flag_n-1:0]    alu_flags_mask;
    logic [flags_pkg::flag_n-1:0]    cur_flags;
    logic                            jump_taken;
    logic [exec_pkg::data_w-1:0]     jump_address;
    logic                            mispredict;
    logic                            accept;
    logic [exec_pkg::pipe_w-1:0]     pipe_in;
    logic [exec_pkg::pipe_w-1:0]     pipe_out;
    logic [$bits(exec_pkg::alu_op_e)-1:0] wb_op_raw;
    logic                            wb_jump_taken;
    logic                            wb_mispredict;

    alu i_alu (
        .op           (e_op),
        .opsize       (e_opsize),
        .cond         (e_cond),
        .op_a         (e_op_a),
        .op_b         (e_op_b),
        .pc           (e_pc),
        .flags_in     (cur_flags),
        .result       (alu_result),
        .flags_out    (alu_flags),
        .flags_mask   (alu_flags_mask),
        .jump_taken   (jump_taken),
        .jump_address (jump_address)
    );

    assign mispredict = jump_taken ^ e_branch_taken;

    // Flags only move on a real transfer that is not being flushed
    assign accept = e_valid && e_ready && !flush;

    eflags i_eflags (
        .clk        (clk),
        .rst        (rst),
        .write      (accept),
        .flags_in   (alu_flags),
        .flags_mask (alu_flags_mask),
        .flags_out  (cur_flags)
    );

    assign pipe_in = {alu_result, e_dest_reg, e_op, jump_taken, jump_address, mispredict};

    pipestage #(
        .width (exec_pkg::pipe_w)
    ) i_pipestage (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (e_valid),
        .in_ready  (e_ready),
        .in_data   (pipe_in),
        .out_valid (wb_valid),
        .out_ready (wb_ready),
        .out_data  (pipe_out)
    );

    assign {wb_result, wb_dest_reg, wb_op_raw, wb_jump_taken, wb_jump_address,
            wb_mispredict} = pipe_out;

    assign wb_alu_op = exec_pkg::alu_op_e'(wb_op_raw);

    // Control bits count only while an item is held
    assign wb_jump_load_address = wb_valid && wb_jump_taken;
    assign wb_br_misprediction  = wb_valid && wb_mispredict;

endmodule

`default_nettype wire

//--- dv/tb_execute_top.sv
// ------------------------------
// Testbench for the execute stage
// Stimulus, reference model and
// output checking assertions
// ------------------------------
`default_nettype none

module tb_execute_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_reset  = 20;
    localparam int n_size   = 60;
    localparam int n_branch = 48;
    localparam int n_dir    = 8;
    localparam int n_bp     = 80;
    localparam int n_flush  = 16;
    localparam int timeout_cycles =
        3 * (n_reset + n_size + n_branch + n_dir + n_bp + n_flush);

    typedef struct packed {
        logic [exec_pkg::data_w-1:0] result;
        logic [exec_pkg::reg_w-1:0]  dest;
        logic [3:0]                  op;
        logic                        jl;
        logic [exec_pkg::data_w-1:0] ja;
        logic                        mp;
    } exp_rec_t;

    logic                        clk;
    logic                        rst;
    logic                        flush;
    logic                        e_valid;
    logic                        e_ready;
    exec_pkg::alu_op_e           e_op;
    exec_pkg::opsize_e           e_opsize;
    flags_pkg::cond_e            e_cond;
    logic [exec_pkg::data_w-1:0] e_op_a;
    logic [exec_pkg::data_w-1:0] e_op_b;
    logic [exec_pkg::data_w-1:0] e_pc;
    logic [exec_pkg::reg_w-1:0]  e_dest_reg;
    logic                        e_branch_taken;
    logic                        wb_ready;
    logic                        wb_valid;
    logic [exec_pkg::data_w-1:0] wb_result;
    logic [exec_pkg::reg_w-1:0]  wb_dest_reg;
    exec_pkg::alu_op_e           wb_alu_op;
    logic                        wb_jump_load_address;
    logic [exec_pkg::data_w-1:0] wb_jump_address;
    logic                        wb_br_misprediction;

    exp_rec_t                     exp_q[$];
    exp_rec_t                     exp_head = '0;
    logic                         exp_valid = 1'b0;
    logic [flags_pkg::flag_n-1:0] model_flags = '0;
    logic [31:0]                  rng = 32'd80;
    logic [31:0]                  stall_rng = 32'd80;
    int                           stall_mode = 0;
    int                           err_count = 0;
    int                           errs_at_start = 0;
    int                           tests_run = 0;
    int                           cycle_count = 0;

    execute_top i_execute_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1103515245 + 32'd12345;
        // Swap halves so low bits come from the better high bits
        return {state[15:0], state[31:16]};
    endfunction

    function automatic exec_pkg::opsize_e rand_size();
        return exec_pkg::opsize_e'(2'(lcg_next(rng) % 32'd3));
    endfunction

    function automatic longint to_signed(input logic [63:0] v, input int unsigned w);
        return v[w-1] ? longint'(v) - longint'(64'd1 << w) : longint'(v);
    endfunction

    function automatic logic fits(input longint v, input int unsigned w);
        return (v >= -(longint'(1) <<< (w - 1))) && (v < (longint'(1) <<< (w - 1)));
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("** Error at %0t: %0s expected 0x%h, got 0x%h", $time, name, exp, got);
        err_count++;
    endtask

    // Reference for one accepted instruction and its flag update
    task automatic model_exec(inout logic [flags_pkg::flag_n-1:0] fl, output exp_rec_t rec);
        int unsigned w;
        logic [63:0] mask;
        logic [63:0] am;
        logic [63:0] bm;
        logic [63:0] full;
        longint      sv;
        logic        cin;
        logic        wr_res;
        logic        cond_ok;
        w = (e_opsize == exec_pkg::size_8) ? 8 : (e_opsize == exec_pkg::size_16) ? 16 : 32;
        mask = (64'd1 << w) - 64'd1;
        am = {32'd0, e_op_a} & mask;
        bm = {32'd0, e_op_b} & mask;
        cin = (e_op == exec_pkg::op_adc) && fl[flags_pkg::flag_cf];
        full = '0;
        sv = 0;
        wr_res = 1'b1;
        case (e_cond)
            flags_pkg::cond_z:  cond_ok = fl[flags_pkg::flag_zf];
            flags_pkg::cond_nz: cond_ok = !fl[flags_pkg::flag_zf];
            flags_pkg::cond_c:  cond_ok = fl[flags_pkg::flag_cf];
            flags_pkg::cond_nc: cond_ok = !fl[flags_pkg::flag_cf];
            flags_pkg::cond_s:  cond_ok = fl[flags_pkg::flag_sf];
            flags_pkg::cond_ns: cond_ok = !fl[flags_pkg::flag_sf];
            flags_pkg::cond_o:  cond_ok = fl[flags_pkg::flag_of];
            default:            cond_ok = 1'b1;
        endcase
        case (e_op)
            exec_pkg::op_add, exec_pkg::op_adc: begin
                full = am + bm + 64'(cin);
                sv = to_signed(am, w) + to_signed(bm, w) + longint'(cin);
            end
            exec_pkg::op_sub, exec_pkg::op_cmp: begin
                full = am - bm;
                sv = to_signed(am, w) - to_signed(bm, w);
            end
            exec_pkg::op_and: full = am & bm;
            exec_pkg::op_or:  full = am | bm;
            exec_pkg::op_xor: full = am ^ bm;
            exec_pkg::op_shl: full = am << e_op_b[4:0];
            exec_pkg::op_shr: full = am >> e_op_b[4:0];
            exec_pkg::op_pass_b: begin
                full = bm;
                wr_res = 1'b0;
            end
            default: wr_res = 1'b0;
        endcase
        rec.result = 32'(full & mask);
        if (wr_res) begin
            if (e_op == exec_pkg::op_add || e_op == exec_pkg::op_adc) begin
                fl[flags_pkg::flag_cf] = full[w];
                fl[flags_pkg::flag_of] = !fits(sv, w);
            end else if (e_op == exec_pkg::op_sub || e_op == exec_pkg::op_cmp) begin
                fl[flags_pkg::flag_cf] = am < bm;
                fl[flags_pkg::flag_of] = !fits(sv, w);
            end else begin
                fl[flags_pkg::flag_cf] = 1'b0;
                fl[flags_pkg::flag_of] = 1'b0;
            end
            fl[flags_pkg::flag_zf] = (rec.result == 32'd0);
            fl[flags_pkg::flag_sf] = rec.result[w-1];
            fl[flags_pkg::flag_pf] = ~^rec.result[7:0];
        end
        if (e_op == exec_pkg::op_std || e_op == exec_pkg::op_cld) begin
            fl[flags_pkg::flag_df] = (e_op == exec_pkg::op_std);
        end
        rec.dest = e_dest_reg;
        rec.op   = e_op;
        rec.jl   = (e_op == exec_pkg::op_jcc) && cond_ok;
        rec.ja   = e_pc + e_op_b;
        rec.mp   = rec.jl != e_branch_taken;
    endtask

    // Queue mirrors the pipe register contents after each edge
    always @(posedge clk) begin
        exp_rec_t rec;
        logic     model_ready;
        if (rst) begin
            exp_q.delete();
            model_flags = '0;
        end else begin
            model_ready = (exp_q.size() == 0) || wb_ready;
            if (wb_ready && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            if (flush) begin
                exp_q.delete();
            end else if (e_valid && model_ready) begin
                model_exec(model_flags, rec);
                exp_q.push_back(rec);
            end
        end
        exp_valid <= (exp_q.size() != 0);
        exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
    end

    a_valid: assert property (@(posedge clk) disable iff (rst) wb_valid == exp_valid)
        else report_mismatch("wb_valid", 32'($sampled(exp_valid)), 32'($sampled(wb_valid)));
    a_ready: assert property (@(posedge clk) disable iff (rst)
        e_ready == (!exp_valid || wb_ready))
        else report_mismatch("e_ready", 32'($sampled(!exp_valid || wb_ready)),
                             32'($sampled(e_ready)));
    a_result: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_result == exp_head.result)
        else report_mismatch("wb_result", $sampled(exp_head.result), $sampled(wb_result));
    a_dest: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_dest_reg == exp_head.dest)
        else report_mismatch("wb_dest_reg", 32'($sampled(exp_head.dest)),
                             32'($sampled(wb_dest_reg)));
    a_op: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_alu_op == exp_head.op)
        else report_mismatch("wb_alu_op", 32'($sampled(exp_head.op)),
                             32'($sampled(wb_alu_op)));
    a_jump_load: assert property (@(posedge clk) disable iff (rst)
        wb_jump_load_address == exp_head.jl)
        else report_mismatch("wb_jump_load_address", 32'($sampled(exp_head.jl)),
                             32'($sampled(wb_jump_load_address)));
    a_jump_addr: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_jump_address == exp_head.ja)
        else report_mismatch("wb_jump_address", $sampled(exp_head.ja),
                             $sampled(wb_jump_address));
    a_mispredict: assert property (@(posedge clk) disable iff (rst)
        wb_br_misprediction == exp_head.mp)
        else report_mismatch("wb_br_misprediction", 32'($sampled(exp_head.mp)),
                             32'($sampled(wb_br_misprediction)));
    a_flags: assert property (@(posedge clk) disable iff (rst)
        i_execute_top.cur_flags == model_flags)
        else report_mismatch("flags", 32'($sampled(model_flags)),
                             32'($sampled(i_execute_top.cur_flags)));
    a_hold: assert property (@(posedge clk) disable iff (rst)
        wb_valid && !wb_ready && !flush |=>
            wb_valid && $stable(wb_result) && $stable(wb_dest_reg) &&
            $stable(wb_alu_op) && $stable(wb_jump_load_address) &&
            $stable(wb_jump_address) && $stable(wb_br_misprediction))
        else begin
            $display("** Error at %0t: writeback outputs changed while stalled", $time);
            err_count++;
        end

    // Mode 0 keeps wb_ready high, 1 stalls at random and 2 holds it low
    initial begin : ready_driver
        int          mode;
        logic [31:0] r;
        wb_ready = 1'b1;
        forever begin
            @(posedge clk);
            mode = stall_mode;
            r = lcg_next(stall_rng);
            #2;
            case (mode)
                0:       wb_ready = 1'b1;
                1:       wb_ready = (r % 32'd100) >= 32'd40;
                default: wb_ready = 1'b0;
            endcase
        end
    end

    task automatic send(input exec_pkg::alu_op_e op, input exec_pkg::opsize_e size,
                        input flags_pkg::cond_e cond, input logic [31:0] a,
                        input logic [31:0] b, input logic pred);
        logic [31:0] r;
        r = lcg_next(rng);
        e_valid        = 1'b1;
        e_op           = op;
        e_opsize       = size;
        e_cond         = cond;
        e_op_a         = a;
        e_op_b         = b;
        e_pc           = {r[31:2], 2'b00};
        e_dest_reg     = r[4:2];
        e_branch_taken = pred;
        @(posedge clk);
        while (!e_ready) @(posedge clk);
        #2;
        e_valid = 1'b0;
    endtask

    task automatic send_random(input int unsigned n_ops);
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        r = lcg_next(rng);
        a = lcg_next(rng);
        b = lcg_next(rng);
        send(exec_pkg::alu_op_e'(4'(r % n_ops)), rand_size(),
             flags_pkg::cond_e'(3'(r >> 8)), a, b, r[12]);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %0s finished, %0d error(s)", name, err_count - errs_at_start);
        errs_at_start = err_count;
        tests_run++;
    endtask

    initial begin : watchdog
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        rst            = 1'b1;
        flush          = 1'b0;
        e_valid        = 1'b0;
        e_op           = exec_pkg::op_add;
        e_opsize       = exec_pkg::size_32;
        e_cond         = flags_pkg::cond_always;
        e_op_a         = '0;
        e_op_b         = '0;
        e_pc           = '0;
        e_dest_reg     = '0;
        e_branch_taken = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        end_test("reset_state");

        repeat (n_size) send_random(10);
        drain();
        end_test("results_by_size");

        for (int i = 0; i < n_branch / 2; i++) begin
            a = lcg_next(rng);
            r = lcg_next(rng);
            b = (r[1:0] == 2'd0) ? a : lcg_next(rng);
            send(exec_pkg::op_cmp, rand_size(), flags_pkg::cond_always, a, b, 1'b0);
            send(exec_pkg::op_jcc, exec_pkg::size_32, flags_pkg::cond_e'(3'(i)), a, r, r[7]);
        end
        drain();
        end_test("flag_branches");

        // Compare flags must survive the DF update in between
        send(exec_pkg::op_cmp, exec_pkg::size_8, flags_pkg::cond_always, 32'h5, 32'h5, 1'b0);
        send(exec_pkg::op_std, exec_pkg::size_32, flags_pkg::cond_always, 0, 0, 1'b0);
        send(exec_pkg::op_jcc, exec_pkg::size_32, flags_pkg::cond_z, 0, 32'h40, 1'b0);
        send(exec_pkg::op_jcc, exec_pkg::size_32, flags_pkg::cond_c, 0, 32'h80, 1'b1);
        send(exec_pkg::op_cmp, exec_pkg::size_16, flags_pkg::cond_always, 32'h1, 32'h2, 1'b0);
        send(exec_pkg::op_cld, exec_pkg::size_32, flags_pkg::cond_always, 0, 0, 1'b0);
        send(exec_pkg::op_jcc, exec_pkg::size_32, flags_pkg::cond_c, 0, 32'h100, 1'b0);
        send(exec_pkg::op_jcc, exec_pkg::size_32, flags_pkg::cond_s, 0, 32'h200, 1'b1);
        drain();
        end_test("direction_flag");

        stall_mode = 1;
        for (int i = 0; i < n_bp; i++) begin
            send_random(13);
            if (lcg_next(rng) % 32'd4 == 32'd0) begin
                @(posedge clk);
                #2;
            end
        end
        stall_mode = 0;
        drain();
        end_test("back_pressure");

        // Flush a held result and then an instruction on offer
        stall_mode = 2;
        send(exec_pkg::op_cmp, exec_pkg::size_32, flags_pkg::cond_always, 32'h7, 32'h7, 1'b0);
        repeat (2) @(posedge clk);
        #2;
        flush = 1'b1;
        @(posedge clk);
        #2;
        stall_mode = 0;
        e_valid  = 1'b1;
        e_op     = exec_pkg::op_cmp;
        e_opsize = exec_pkg::size_32;
        e_op_a   = 32'h1;
        e_op_b   = 32'h2;
        @(posedge clk);
        #2;
        flush   = 1'b0;
        e_valid = 1'b0;
        send(exec_pkg::op_jcc, exec_pkg::size_32, flags_pkg::cond_z, 0, 32'h10, 1'b0);
        send(exec_pkg::op_jcc, exec_pkg::size_32, flags_pkg::cond_c, 0, 32'h20, 1'b0);
        send(exec_pkg::op_jcc, exec_pkg::size_32, flags_pkg::cond_s, 0, 32'h30, 1'b1);
        send(exec_pkg::op_jcc, exec_pkg::size_32, flags_pkg::cond_o, 0, 32'h40, 1'b0);
        drain();
        end_test("flush");

        repeat (2) @(posedge clk);
        $display("%0d tests run, %0d check(s) failed", tests_run, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
src/exec_pkg.sv
src/flags_pkg.sv
src/alu.sv
src/eflags.sv
src/pipestage.sv
src/execute_top.sv
dv/tb_execute_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_execute_top -f vlog.f -o sim_exec --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_exec > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$log"; then
    echo "Simulation failed, see $log"
    exit 1
fi

echo "Simulation passed"
exit 0
